/* design/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  stall,
    input  logic [xlen-1:0]       pc,
    input  logic [xlen-1:0]       r1,
    input  logic [xlen-1:0]       r2,
    input  logic [xlen-1:0]       imm,
    input  logic [reg_addr_w-1:0] rd,
    input  ctrl_t                 ctrl,
    output logic                  out_valid,
    input  logic                  out_ready,
    output id_out_t               out_bundle
);

    logic            accept;
    logic [xlen-1:0] op2;

    // Free slot when empty or draining this cycle
    assign in_ready = !stall && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    assign op2 = ctrl.use_imm ? imm : r2;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Bundle only moves on a transfer, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            out_bundle.pc   <= pc;
            out_bundle.r1   <= r1;
            out_bundle.r2   <= op2;
            out_bundle.imm  <= imm;
            out_bundle.rd   <= rd;
            out_bundle.ctrl <= ctrl;
        end
    end

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ps

module id_stage import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [xlen-1:0]       in_pc,
    input  logic [xlen-1:0]       in_inst,
    output logic [reg_addr_w-1:0] r1_addr,
    output logic                  r1_read,
    output logic [reg_addr_w-1:0] r2_addr,
    output logic                  r2_read,
    input  logic [xlen-1:0]       r1_data,
    input  logic [xlen-1:0]       r2_data,
    input  fwd_t                  ex_fwd,
    input  logic                  ld_flag,
    input  fwd_t                  mem_fwd,
    output logic                  out_valid,
    input  logic                  out_ready,
    output id_out_t               out_bundle
);

    ctrl_t                 ctrl;
    imm_fmt_e              imm_fmt;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       r1_val;
    logic [xlen-1:0]       r2_val;
    logic                  r1_hazard;
    logic                  r2_hazard;
    logic                  stall;
    logic [reg_addr_w-1:0] rd;

    assign r1_addr = in_inst[19:15];
    assign r2_addr = in_inst[24:20];
    assign rd      = in_inst[11:7];
    assign r1_read = ctrl.r1_read;
    assign r2_read = ctrl.r2_read;
    assign stall   = r1_hazard | r2_hazard;

    inst_decoder u_dec (
        .inst    (in_inst),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .inst    (in_inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    operand_forward u_fwd_r1 (
        .addr     (r1_addr),
        .read     (ctrl.r1_read),
        .reg_data (r1_data),
        .ex_fwd   (ex_fwd),
        .ld_flag  (ld_flag),
        .mem_fwd  (mem_fwd),
        .operand  (r1_val),
        .hazard   (r1_hazard)
    );

    operand_forward u_fwd_r2 (
        .addr     (r2_addr),
        .read     (ctrl.r2_read),
        .reg_data (r2_data),
        .ex_fwd   (ex_fwd),
        .ld_flag  (ld_flag),
        .mem_fwd  (mem_fwd),
        .operand  (r2_val),
        .hazard   (r2_hazard)
    );

    id_ex_reg u_out (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .stall      (stall),
        .pc         (in_pc),
        .r1         (r1_val),
        .r2         (r2_val),
        .imm        (imm),
        .rd         (rd),
        .ctrl       (ctrl),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

endmodule

/* design/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rv_decode_pkg::*; (
    input  logic [xlen-1:0] inst,
    input  imm_fmt_e        imm_fmt,
    output logic [xlen-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            imm_i_shift: begin
                imm = {{(xlen-5){1'b0}}, inst[24:20]};   // shamt, zero-extended
            end
            imm_s: begin
                imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            imm_b: begin
                imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            imm_u: begin
                imm = {inst[31:12], 12'h000};
            end
            imm_j: begin
                imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import rv_decode_pkg::*; (
    input  logic [xlen-1:0] inst,
    output ctrl_t           ctrl,
    output imm_fmt_e        imm_fmt
);

    opcode_e    opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    alu_op_e    alu_op;
    res_sel_e   res_sel;
    imm_fmt_e   fmt;
    logic       rd_enable;
    logic       r1_read;
    logic       r2_read;
    logic       use_imm;

    assign opcode = opcode_e'(inst[6:0]);
    assign func3  = inst[14:12];
    assign func7  = inst[31:25];

    // Anything not matched below stays a nop
    always_comb begin
        alu_op    = alu_nop;
        fmt       = imm_none;
        rd_enable = 1'b0;
        r1_read   = 1'b0;
        r2_read   = 1'b0;
        use_imm   = 1'b0;
        case (opcode)
            opc_op: begin
                case (func7)
                    7'b0000000: begin
                        case (func3)
                            3'b000:  alu_op = alu_add;
                            3'b001:  alu_op = alu_sll;
                            3'b010:  alu_op = alu_slt;
                            3'b011:  alu_op = alu_sltu;
                            3'b100:  alu_op = alu_xor;
                            3'b101:  alu_op = alu_srl;
                            3'b110:  alu_op = alu_or;
                            default: alu_op = alu_and;
                        endcase
                    end
                    7'b0100000: begin
                        case (func3)
                            3'b000:  alu_op = alu_sub;
                            3'b101:  alu_op = alu_sra;
                            default: alu_op = alu_nop;
                        endcase
                    end
                    default: alu_op = alu_nop;
                endcase
                if (alu_op != alu_nop) begin
                    rd_enable = 1'b1;
                    r1_read   = 1'b1;
                    r2_read   = 1'b1;
                end
            end
            opc_op_imm: begin
                case (func3)
                    3'b000:  alu_op = alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: begin   // func7 picks logical or arithmetic right shift
                        if (func7 == 7'b0000000) begin
                            alu_op = alu_srl;
                        end else if (func7 == 7'b0100000) begin
                            alu_op = alu_sra;
                        end
                    end
                endcase
                if (alu_op != alu_nop) begin
                    rd_enable = 1'b1;
                    r1_read   = 1'b1;
                    use_imm   = 1'b1;
                    fmt       = (func3[1:0] == 2'b01) ? imm_i_shift : imm_i;
                end
            end
            opc_lui: begin
                alu_op    = alu_or;   // x0 | imm
                rd_enable = 1'b1;
                use_imm   = 1'b1;
                fmt       = imm_u;
            end
            opc_auipc: begin
                alu_op    = alu_auipc;
                rd_enable = 1'b1;
                fmt       = imm_u;
            end
            opc_load: begin
                case (func3)
                    3'b000:  alu_op = alu_lb;
                    3'b001:  alu_op = alu_lh;
                    3'b010:  alu_op = alu_lw;
                    3'b100:  alu_op = alu_lbu;
                    3'b101:  alu_op = alu_lhu;
                    default: alu_op = alu_nop;
                endcase
                if (alu_op != alu_nop) begin
                    rd_enable = 1'b1;
                    r1_read   = 1'b1;
                    fmt       = imm_i;
                end
            end
            opc_store: begin
                case (func3)
                    3'b000:  alu_op = alu_sb;
                    3'b001:  alu_op = alu_sh;
                    3'b010:  alu_op = alu_sw;
                    default: alu_op = alu_nop;
                endcase
                if (alu_op != alu_nop) begin
                    r1_read = 1'b1;
                    r2_read = 1'b1;
                    fmt     = imm_s;
                end
            end
            opc_branch: begin
                case (func3)
                    3'b000:  alu_op = alu_beq;
                    3'b001:  alu_op = alu_bne;
                    3'b100:  alu_op = alu_blt;
                    3'b101:  alu_op = alu_bge;
                    3'b110:  alu_op = alu_bltu;
                    3'b111:  alu_op = alu_bgeu;
                    default: alu_op = alu_nop;
                endcase
                if (alu_op != alu_nop) begin
                    r1_read = 1'b1;
                    r2_read = 1'b1;
                    fmt     = imm_b;
                end
            end
            opc_jal: begin
                alu_op    = alu_jal;
                rd_enable = 1'b1;
                fmt       = imm_j;
            end
            opc_jalr: begin
                alu_op    = alu_jalr;
                rd_enable = 1'b1;
                r1_read   = 1'b1;
                fmt       = imm_i;
            end
            default: alu_op = alu_nop;
        endcase
    end

    // Result class follows from the operation
    always_comb begin
        case (alu_op)
            alu_add, alu_sub, alu_slt, alu_sltu, alu_auipc: res_sel = res_arith;
            alu_xor, alu_or, alu_and:                       res_sel = res_logic;
            alu_sll, alu_srl, alu_sra:                      res_sel = res_shift;
            alu_lb, alu_lh, alu_lw, alu_lbu, alu_lhu,
            alu_sb, alu_sh, alu_sw:                         res_sel = res_ld_st;
            alu_jal, alu_jalr:                              res_sel = res_jump;
            default:                                        res_sel = res_nop;   // Branches too
        endcase
    end

    assign ctrl.alu_op    = alu_op;
    assign ctrl.res_sel   = res_sel;
    assign ctrl.rd_enable = rd_enable;
    assign ctrl.r1_read   = r1_read;
    assign ctrl.r2_read   = r2_read;
    assign ctrl.use_imm   = use_imm;
    assign imm_fmt        = fmt;

endmodule

/* design/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import rv_decode_pkg::*; (
    input  logic [reg_addr_w-1:0] addr,
    input  logic                  read,
    input  logic [xlen-1:0]       reg_data,
    input  fwd_t                  ex_fwd,
    input  logic                  ld_flag,
    input  fwd_t                  mem_fwd,
    output logic [xlen-1:0]       operand,
    output logic                  hazard
);

    logic live;
    logic ex_hit;
    logic mem_hit;

    assign live    = read && (addr != '0);   // x0 never forwards
    assign ex_hit  = live && ex_fwd.flag && (ex_fwd.addr == addr);
    assign mem_hit = live && mem_fwd.flag && (mem_fwd.addr == addr);

    // Load data is not ready until after memory
    assign hazard = live && ld_flag && (ex_fwd.addr == addr);

    always_comb begin
        if (!live || hazard) begin
            operand = '0;
        end else if (ex_hit) begin
            operand = ex_fwd.data;   // Youngest result wins
        end else if (mem_hit) begin
            operand = mem_fwd.data;
        end else begin
            operand = reg_data;
        end
    end

endmodule

/* design/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // RV32I major opcodes, bits 6:0
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [4:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_lb,
        alu_lh,
        alu_lw,
        alu_lbu,
        alu_lhu,
        alu_sb,
        alu_sh,
        alu_sw,
        alu_auipc,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu,
        alu_jal,
        alu_jalr
    } alu_op_e;

    typedef enum logic [2:0] {
        res_nop,
        res_arith,
        res_logic,
        res_shift,
        res_ld_st,
        res_jump
    } res_sel_e;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_i_shift,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_e;

    typedef struct packed {
        alu_op_e  alu_op;
        res_sel_e res_sel;
        logic     rd_enable;
        logic     r1_read;
        logic     r2_read;
        logic     use_imm;   // Operand 2 takes the immediate
    } ctrl_t;

    typedef struct packed {
        logic                  flag;   // Later stage writes addr
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } fwd_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       r1;
        logic [xlen-1:0]       r2;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        ctrl_t                 ctrl;
    } id_out_t;

endpackage

/* id_stage.f */
design/rv_decode_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/operand_forward.sv
design/id_ex_reg.sv
design/id_stage.sv
sim/id_stage_asserts.sv
sim/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f > build.log 2>&1 &&
    ./obj_dir/Vid_stage_tb > sim.log 2>&1 ||
    { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

if grep -q "Verification failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* sim/id_stage_asserts.sv */
`timescale 1ns/1ps

module id_stage_asserts import rv_decode_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_ready,
    input logic [reg_addr_w-1:0] r1_addr,
    input logic                  r1_read,
    input logic [reg_addr_w-1:0] r2_addr,
    input logic                  r2_read,
    input fwd_t                  ex_fwd,
    input logic                  ld_flag,
    input logic                  out_valid,
    input logic                  out_ready,
    input id_out_t               out_bundle
);

    logic load_use;

    // Load in execute targets a live source register
    assign load_use = ld_flag && ((r1_read && r1_addr != '0 && r1_addr == ex_fwd.addr) ||
                                  (r2_read && r2_addr != '0 && r2_addr == ex_fwd.addr));

    hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle))
        else $error("out_bundle changed or dropped under back-pressure");

    no_accept_on_hazard: assert property (@(posedge clk) disable iff (rst)
        load_use |-> !in_ready)
        else $error("in_ready high during a load-use hazard");

    empty_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after reset");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk (clk), .rst (rst), .in_ready (in_ready), .r1_addr (r1_addr), .r1_read (r1_read),
    .r2_addr (r2_addr), .r2_read (r2_read), .ex_fwd (ex_fwd), .ld_flag (ld_flag),
    .out_valid (out_valid), .out_ready (out_ready), .out_bundle (out_bundle)
);

/* sim/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import rv_decode_pkg::*; ();

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [xlen-1:0]       in_pc;
    logic [xlen-1:0]       in_inst;
    logic [reg_addr_w-1:0] r1_addr;
    logic                  r1_read;
    logic [reg_addr_w-1:0] r2_addr;
    logic                  r2_read;
    logic [xlen-1:0]       r1_data;
    logic [xlen-1:0]       r2_data;
    fwd_t                  ex_fwd;
    logic                  ld_flag;
    fwd_t                  mem_fwd;
    logic                  out_valid;
    logic                  out_ready;
    id_out_t               out_bundle;

    logic [xlen-1:0] regs [0:31];
    id_out_t         exp_q [$];
    integer          seed = 32'h2ec5_3610;
    int              error_count;
    int              check_count;
    int              test_errors;
    int              test_checks;
    string           cur_test;
    logic            bp_mode;
    logic [xlen-1:0] next_pc;

    // Indexed by func3
    alu_op_e  base_ops [0:7]   = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                   alu_xor, alu_srl, alu_or, alu_and};
    res_sel_e base_cls [0:7]   = '{res_arith, res_shift, res_arith, res_arith,
                                   res_logic, res_shift, res_logic, res_logic};
    alu_op_e  load_ops [0:7]   = '{alu_lb, alu_lh, alu_lw, alu_nop,
                                   alu_lbu, alu_lhu, alu_nop, alu_nop};
    alu_op_e  store_ops [0:7]  = '{alu_sb, alu_sh, alu_sw, alu_nop,
                                   alu_nop, alu_nop, alu_nop, alu_nop};
    alu_op_e  branch_ops [0:7] = '{alu_beq, alu_bne, alu_nop, alu_nop,
                                   alu_blt, alu_bge, alu_bltu, alu_bgeu};
    logic [6:0] any_opcs [0:15] = '{opc_op, opc_op_imm, opc_lui, opc_auipc, opc_load,
                                    opc_store, opc_branch, opc_jal, opc_jalr, opc_op,
                                    opc_op_imm, opc_load, opc_store, opc_branch,
                                    7'h7f, 7'h0b};   // Last two are unknown encodings

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Register file answers in the same cycle
    assign r1_data = regs[r1_addr];
    assign r2_data = regs[r2_addr];

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [xlen-1:0] pick_operand(input logic [4:0] addr, input logic read,
                                                     input fwd_t exf, input fwd_t memf);
        if (!read || addr == 5'd0) begin
            return '0;
        end
        if (exf.flag && exf.addr == addr) begin
            return exf.data;
        end
        if (memf.flag && memf.addr == addr) begin
            return memf.data;
        end
        return regs[addr];
    endfunction

    function automatic id_out_t expect_bundle(input logic [31:0] inst, input logic [31:0] pc,
                                              input fwd_t exf, input fwd_t memf);
        id_out_t     b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] i_imm;
        b     = '0;
        f3    = inst[14:12];
        f7    = inst[31:25];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        b.pc  = pc;
        b.rd  = inst[11:7];
        case (inst[6:0])
            opc_op: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    if (f7 == 7'h00) begin
                        b.ctrl.alu_op = base_ops[f3];
                    end else if (f3 == 3'd0) begin
                        b.ctrl.alu_op = alu_sub;
                    end else begin
                        b.ctrl.alu_op = alu_sra;
                    end
                    b.ctrl.res_sel   = base_cls[f3];
                    b.ctrl.rd_enable = 1'b1;
                    b.ctrl.r1_read   = 1'b1;
                    b.ctrl.r2_read   = 1'b1;
                end
            end
            opc_op_imm: begin
                if (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20) begin
                    b.ctrl.alu_op = base_ops[f3];
                    if (f3 == 3'd5 && f7 == 7'h20) begin
                        b.ctrl.alu_op = alu_sra;
                    end
                    b.ctrl.res_sel   = base_cls[f3];
                    b.ctrl.rd_enable = 1'b1;
                    b.ctrl.r1_read   = 1'b1;
                    b.ctrl.use_imm   = 1'b1;
                    b.imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, inst[24:20]} : i_imm;
                end
            end
            opc_lui, opc_auipc: begin
                b.ctrl.alu_op    = (inst[5]) ? alu_or : alu_auipc;
                b.ctrl.res_sel   = (inst[5]) ? res_logic : res_arith;
                b.ctrl.rd_enable = 1'b1;
                b.ctrl.use_imm   = inst[5];   // LUI only
                b.imm            = {inst[31:12], 12'd0};
            end
            opc_load: begin
                if (load_ops[f3] != alu_nop) begin
                    b.ctrl.alu_op    = load_ops[f3];
                    b.ctrl.res_sel   = res_ld_st;
                    b.ctrl.rd_enable = 1'b1;
                    b.ctrl.r1_read   = 1'b1;
                    b.imm            = i_imm;
                end
            end
            opc_store: begin
                if (store_ops[f3] != alu_nop) begin
                    b.ctrl.alu_op  = store_ops[f3];
                    b.ctrl.res_sel = res_ld_st;
                    b.ctrl.r1_read = 1'b1;
                    b.ctrl.r2_read = 1'b1;
                    b.imm          = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                end
            end
            opc_branch: begin
                if (branch_ops[f3] != alu_nop) begin
                    b.ctrl.alu_op  = branch_ops[f3];
                    b.ctrl.r1_read = 1'b1;
                    b.ctrl.r2_read = 1'b1;
                    b.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            opc_jal: begin
                b.ctrl.alu_op    = alu_jal;
                b.ctrl.res_sel   = res_jump;
                b.ctrl.rd_enable = 1'b1;
                b.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opc_jalr: begin
                b.ctrl.alu_op    = alu_jalr;
                b.ctrl.res_sel   = res_jump;
                b.ctrl.rd_enable = 1'b1;
                b.ctrl.r1_read   = 1'b1;
                b.imm            = i_imm;
            end
            default: begin
                b.imm = '0;
            end
        endcase
        b.r1 = pick_operand(inst[19:15], b.ctrl.r1_read, exf, memf);
        b.r2 = b.ctrl.use_imm ? b.imm : pick_operand(inst[24:20], b.ctrl.r2_read, exf, memf);
        return b;
    endfunction

    function automatic fwd_t random_fwd();
        fwd_t        f;
        logic [31:0] r;
        r      = rand32();
        f.flag = r[0];
        f.addr = {3'b000, r[2:1]};   // Small range so matches are common
        f.data = rand32();
        return f;
    endfunction

    // Output transfers are checked before the accepting edge queues a new entry
    always @(posedge clk) begin
        id_out_t exp;
        id_out_t nxt;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output bundle appeared with nothing expected in test %s", cur_test);
                error_count++;
            end else begin
                exp = exp_q.pop_front();
                check_count++;
                assert (out_bundle == exp) else begin
                    $display("CHECK FAILED %s expected %h actual %h", cur_test, exp, out_bundle);
                    error_count++;
                end
            end
        end
        if (!rst && in_valid && in_ready) begin
            nxt = expect_bundle(in_inst, in_pc, ex_fwd, mem_fwd);
            check_count++;
            // Register file read enables go out with the instruction
            assert (r1_read == nxt.ctrl.r1_read && r2_read == nxt.ctrl.r2_read) else begin
                $display("CHECK FAILED %s read enables expected %b%b actual %b%b", cur_test,
                         nxt.ctrl.r1_read, nxt.ctrl.r2_read, r1_read, r2_read);
                error_count++;
            end
            exp_q.push_back(nxt);
        end
    end

    always @(posedge clk) begin
        logic [31:0] r;
        if (bp_mode) begin
            r = rand32();
            out_ready <= r[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    task automatic give_up(input string what);
        error_count++;
        $display("Timeout: %s in test %s", what, cur_test);
        $display("Tests done: %0d checks, %0d errors", check_count, error_count);
        $display("Verification failed");
        $finish;
    endtask

    task automatic present(input logic [31:0] inst);
        in_valid <= 1'b1;
        in_inst  <= inst;
        in_pc    <= next_pc;
        next_pc  = next_pc + 32'd4;
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > 200) begin
                give_up("instruction never accepted");
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic send(input logic [31:0] inst);
        present(inst);
        wait_accept();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 500) begin
                give_up("expected bundles never left the stage");
            end
            @(posedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = error_count;
        test_checks = check_count;
    endtask

    task automatic finish_test();
        drain();
        $display("Test %s: %0d checks, %0d errors", cur_test, check_count - test_checks,
                 error_count - test_errors);
    endtask

    initial begin
        logic [31:0] inst;
        fwd_t        f;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_inst     = '0;
        ex_fwd      = '0;
        ld_flag     = 1'b0;
        mem_fwd     = '0;
        out_ready   = 1'b1;
        bp_mode     = 1'b0;
        next_pc     = 32'h0000_1000;
        error_count = 0;
        check_count = 0;
        cur_test    = "reset";
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = rand32();   // x0 too, DUT must ignore it
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test("r_type");
        for (int i = 0; i < 24; i++) begin
            inst        = rand32();
            inst[6:0]   = opc_op;
            inst[14:12] = i[2:0];
            inst[31:25] = (i < 8) ? 7'h00 : ((i < 16) ? 7'h20 : 7'h01);
            if (i[2:0] == 3'd0) begin
                inst[19:15] = 5'd0;
            end
            if (i[2:0] == 3'd1) begin
                inst[24:20] = 5'd0;
            end
            send(inst);
        end
        finish_test();

        start_test("imm_lui_auipc");
        for (int i = 0; i < 32; i++) begin
            inst        = rand32();
            inst[6:0]   = (i < 24) ? opc_op_imm : (i[0] ? opc_lui : opc_auipc);
            inst[14:12] = (i < 24) ? i[2:0] : inst[14:12];
            if (i < 24 && (i[2:0] == 3'd1 || i[2:0] == 3'd5)) begin
                inst[31:25] = (i < 8) ? 7'h00 : ((i < 16) ? 7'h20 : 7'h04);
            end
            send(inst);
        end
        finish_test();

        start_test("mem_branch_jump");
        for (int i = 0; i < 32; i++) begin
            inst = rand32();
            case (i / 8)
                0:       inst[6:0] = opc_load;
                1:       inst[6:0] = opc_store;
                2:       inst[6:0] = opc_branch;
                default: inst[6:0] = i[0] ? opc_jal : opc_jalr;
            endcase
            if (i < 24) begin
                inst[14:12] = i[2:0];
            end
            send(inst);
        end
        finish_test();

        start_test("forwarding");
        for (int i = 0; i < 40; i++) begin
            inst        = rand32();
            inst[6:0]   = i[0] ? opc_op : opc_store;
            inst[14:12] = 3'd0;
            inst[31:25] = 7'h00;
            inst[19:15] = {3'b000, inst[16:15]};   // x0..x3 only
            inst[24:20] = {3'b000, inst[21:20]};
            ex_fwd  <= random_fwd();
            mem_fwd <= random_fwd();
            send(inst);
        end
        ex_fwd  <= '0;
        mem_fwd <= '0;
        finish_test();

        start_test("load_use_stall");
        for (int i = 0; i < 4; i++) begin
            inst        = rand32();
            inst[6:0]   = opc_op;
            inst[14:12] = 3'd0;
            inst[31:25] = 7'h00;
            inst[19:15] = 5'd4 + i[4:0];
            inst[24:20] = 5'd12;
            f.flag  = 1'b1;
            f.addr  = i[0] ? inst[24:20] : inst[19:15];
            f.data  = rand32();
            ld_flag <= 1'b1;
            ex_fwd  <= f;
            present(inst);
            repeat (5) begin
                @(posedge clk);
                check_count++;
                assert (!in_ready) else begin
                    $display("Instruction accepted during load-use stall in test %s", cur_test);
                    error_count++;
                end
            end
            ld_flag <= 1'b0;
            wait_accept();
        end
        inst        = rand32();
        inst[6:0]   = opc_op;
        inst[14:12] = 3'd0;
        inst[31:25] = 7'h00;
        inst[19:15] = 5'd0;
        f.addr      = 5'd0;
        ld_flag     <= 1'b1;
        ex_fwd      <= f;
        send(inst);   // x0 source never stalls
        ld_flag <= 1'b0;
        ex_fwd  <= '0;
        finish_test();

        start_test("back_pressure");
        bp_mode = 1'b1;
        for (int i = 0; i < 60; i++) begin
            inst      = rand32();
            inst[6:0] = any_opcs[inst[3:0]];
            if (inst[31]) begin
                @(posedge clk);   // Idle gap
            end
            send(inst);
        end
        bp_mode = 1'b0;
        finish_test();

        $display("Tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
